//--- filelist.f
source/core_pkg.sv
source/div_if.sv
source/alu.sv
source/divider.sv
source/forwarding_unit.sv
source/register_file.sv
source/execute_stage.sv
source/execute_core.sv
testbench/execute_core_asserts.sv
testbench/execute_core_tb.sv

//--- source/alu.sv
module alu
  import core_pkg::*;
(
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic [2:0] funct3,
  input  logic alt,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;

  always_comb begin
    shamt = b[4:0];
    case (funct3)
      funct3_add: result = alt ? a - b : a + b;
      funct3_sll: result = a << shamt;
      funct3_slt: result = xlen'($signed(a) < $signed(b));
      funct3_sltu: result = xlen'(a < b);
      funct3_xor: result = a ^ b;
      funct3_srl: begin
        // Arithmetic shift keeps the sign bit of a
        if (alt) begin
          result = $unsigned($signed(a) >>> shamt);
        end else begin
          result = a >> shamt;
        end
      end
      funct3_or: result = a | b;
      funct3_and: result = a & b;
      default: result = '0;
    endcase
  end

endmodule

//--- source/core_pkg.sv
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  // ------------------------------
  // Major opcodes
  // ------------------------------
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // ------------------------------
  // Function codes
  // ------------------------------
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl = 3'b101;
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  // Bit 0 selects unsigned and bit 1 selects the remainder
  localparam logic [2:0] funct3_div = 3'b100;
  localparam logic [2:0] funct3_divu = 3'b101;
  localparam logic [2:0] funct3_rem = 3'b110;
  localparam logic [2:0] funct3_remu = 3'b111;

  // The same word seen as an R-type or an I-type instruction
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [reg_addr_width-1:0] rs2;
      logic [reg_addr_width-1:0] rs1;
      logic [2:0] funct3;
      logic [reg_addr_width-1:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic signed [11:0] imm;
      logic [reg_addr_width-1:0] rs1;
      logic [2:0] funct3;
      logic [reg_addr_width-1:0] rd;
      logic [6:0] opcode;
    } i;
  } instr_word_t;

  // addi x0,x0,0
  localparam instr_word_t nop_word = 32'h0000_0013;

endpackage

//--- source/div_if.sv
interface div_if;

  logic req;
  logic ack;
  // Bit 0 is unsigned, bit 1 asks for the remainder
  logic [1:0] op;
  logic [31:0] dividend;
  logic [31:0] divisor;
  logic [31:0] result;

  modport requester (
    output req, op, dividend, divisor,
    input ack, result
  );

  modport responder (
    input req, op, dividend, divisor,
    output ack, result
  );

endinterface

//--- source/divider.sv
module divider
  import core_pkg::*;
(
  input logic clock,
  input logic reset,
  div_if.responder div
);

  logic busy;
  logic start;
  logic is_signed;
  logic [4:0] count;
  logic [xlen-1:0] quo, rem, dvs;
  logic [xlen-1:0] dividend_abs, divisor_abs;
  logic [xlen-1:0] quo_next, rem_next;
  logic [xlen:0] rem_shift, diff;
  logic neg_quo, neg_rem;

  always_comb begin
    start = div.req & ~busy & ~div.ack;
    is_signed = ~div.op[0];
    dividend_abs = (is_signed && div.dividend[xlen-1]) ? -div.dividend : div.dividend;
    divisor_abs = (is_signed && div.divisor[xlen-1]) ? -div.divisor : div.divisor;
    // One restoring step, the next dividend bit shifts in from quo
    rem_shift = {rem, quo[xlen-1]};
    diff = rem_shift - {1'b0, dvs};
    if (diff[xlen] == 0) begin
      rem_next = diff[xlen-1:0];
      quo_next = {quo[xlen-2:0], 1'b1};
    end else begin
      rem_next = rem_shift[xlen-1:0];
      quo_next = {quo[xlen-2:0], 1'b0};
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy <= 0;
      count <= '0;
      div.ack <= 0;
    end else if (start) begin
      busy <= 1;
      count <= '0;
    end else if (busy) begin
      count <= count + 1;
      if (count == 5'(xlen - 1)) begin
        busy <= 0;
        div.ack <= 1;
      end
    end else if (div.ack && !div.req) begin
      div.ack <= 0;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      quo <= dividend_abs;
      rem <= '0;
      dvs <= divisor_abs;
      // Division by zero keeps the all-ones quotient
      neg_quo <= is_signed & (div.dividend[xlen-1] ^ div.divisor[xlen-1]) & (div.divisor != 0);
      neg_rem <= is_signed & div.dividend[xlen-1];
    end else if (busy) begin
      quo <= quo_next;
      rem <= rem_next;
      if (count == 5'(xlen - 1)) begin
        if (div.op[1]) begin
          div.result <= neg_rem ? -rem_next : rem_next;
        end else begin
          div.result <= neg_quo ? -quo_next : quo_next;
        end
      end
    end
  end

endmodule

//--- source/execute_core.sv
module execute_core
  import core_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic issue_valid,
  input  instr_word_t instr0,
  input  instr_word_t instr1,
  output logic issue_ready,
  output logic wb_valid0,
  output logic [reg_addr_width-1:0] wb_rd0,
  output logic [xlen-1:0] wb_data0,
  output logic wb_valid1,
  output logic [reg_addr_width-1:0] wb_rd1,
  output logic [xlen-1:0] wb_data1
);

  logic [reg_addr_width-1:0] raddr0_1, raddr0_2, raddr1_1, raddr1_2;
  logic [xlen-1:0] rdata0_1, rdata0_2, rdata1_1, rdata1_2;
  logic [xlen-1:0] fdata0_1, fdata0_2, fdata1_1, fdata1_2;
  logic [xlen-1:0] alu0_a, alu0_b, alu0_result;
  logic [xlen-1:0] alu1_a, alu1_b, alu1_result;
  logic [2:0] alu0_funct3, alu1_funct3;
  logic alu0_alt, alu1_alt;

  div_if div_bus ();

  execute_stage execute_stage_0 (
    .clock, .reset, .issue_valid, .instr0, .instr1, .issue_ready,
    .raddr0_1, .raddr0_2, .raddr1_1, .raddr1_2,
    .fdata0_1, .fdata0_2, .fdata1_1, .fdata1_2,
    .alu0_a, .alu0_b, .alu0_funct3, .alu0_alt, .alu0_result,
    .alu1_a, .alu1_b, .alu1_funct3, .alu1_alt, .alu1_result,
    .div(div_bus),
    .res_valid0(wb_valid0), .res_rd0(wb_rd0), .res_data0(wb_data0),
    .res_valid1(wb_valid1), .res_rd1(wb_rd1), .res_data1(wb_data1)
  );

  alu alu0 (.a(alu0_a), .b(alu0_b), .funct3(alu0_funct3), .alt(alu0_alt), .result(alu0_result));
  alu alu1 (.a(alu1_a), .b(alu1_b), .funct3(alu1_funct3), .alt(alu1_alt), .result(alu1_result));

  divider divider_0 (.clock, .reset, .div(div_bus));

  forwarding_unit forwarding_unit_0 (
    .raddr0_1, .raddr0_2, .raddr1_1, .raddr1_2,
    .rdata0_1, .rdata0_2, .rdata1_1, .rdata1_2,
    .res_valid0(wb_valid0), .res_rd0(wb_rd0), .res_data0(wb_data0),
    .res_valid1(wb_valid1), .res_rd1(wb_rd1), .res_data1(wb_data1),
    .fdata0_1, .fdata0_2, .fdata1_1, .fdata1_2
  );

  // The register file is written from the result register
  register_file register_file_0 (
    .clock, .reset,
    .raddr0_1, .raddr0_2, .raddr1_1, .raddr1_2,
    .rdata0_1, .rdata0_2, .rdata1_1, .rdata1_2,
    .wen0(wb_valid0), .waddr0(wb_rd0), .wdata0(wb_data0),
    .wen1(wb_valid1), .waddr1(wb_rd1), .wdata1(wb_data1)
  );

endmodule

//--- source/execute_stage.sv
module execute_stage
  import core_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic issue_valid,
  input  instr_word_t instr0,
  input  instr_word_t instr1,
  output logic issue_ready,
  output logic [reg_addr_width-1:0] raddr0_1,
  output logic [reg_addr_width-1:0] raddr0_2,
  output logic [reg_addr_width-1:0] raddr1_1,
  output logic [reg_addr_width-1:0] raddr1_2,
  input  logic [xlen-1:0] fdata0_1,
  input  logic [xlen-1:0] fdata0_2,
  input  logic [xlen-1:0] fdata1_1,
  input  logic [xlen-1:0] fdata1_2,
  output logic [xlen-1:0] alu0_a,
  output logic [xlen-1:0] alu0_b,
  output logic [2:0] alu0_funct3,
  output logic alu0_alt,
  input  logic [xlen-1:0] alu0_result,
  output logic [xlen-1:0] alu1_a,
  output logic [xlen-1:0] alu1_b,
  output logic [2:0] alu1_funct3,
  output logic alu1_alt,
  input  logic [xlen-1:0] alu1_result,
  div_if.requester div,
  output logic res_valid0,
  output logic [reg_addr_width-1:0] res_rd0,
  output logic [xlen-1:0] res_data0,
  output logic res_valid1,
  output logic [reg_addr_width-1:0] res_rd1,
  output logic [xlen-1:0] res_data1
);

  logic pending;
  logic hold_valid0, hold_valid1;
  logic accept, div_done;
  logic is_div0, wb0, wb1;

  // ------------------------------
  // Decode
  // ------------------------------
  function automatic logic alu_legal(instr_word_t w);
    logic shift;
    shift = (w.r.funct3 == funct3_sll) || (w.r.funct3 == funct3_srl);
    if (w.r.opcode == opcode_op) begin
      return (w.r.funct7 == funct7_base) || (w.r.funct7 == funct7_alt &&
             (w.r.funct3 == funct3_add || w.r.funct3 == funct3_srl));
    end else if (w.r.opcode == opcode_op_imm) begin
      return !shift || w.r.funct7 == funct7_base ||
             (w.r.funct7 == funct7_alt && w.r.funct3 == funct3_srl);
    end
    return 1'b0;
  endfunction

  // Only sub, sra and srai use the alternate form, addi never does
  function automatic logic alu_alt(instr_word_t w);
    if (w.r.opcode == opcode_op) begin
      return w.r.funct7 == funct7_alt;
    end
    return w.r.funct3 == funct3_srl && w.r.funct7 == funct7_alt;
  endfunction

  function automatic logic [xlen-1:0] operand_b(instr_word_t w, logic [xlen-1:0] rs2_value);
    if (w.r.opcode == opcode_op) begin
      return rs2_value;
    end
    return {{(xlen - 12){w.i.imm[11]}}, w.i.imm};
  endfunction

  assign raddr0_1 = instr0.r.rs1;
  assign raddr0_2 = instr0.r.rs2;
  assign raddr1_1 = instr1.r.rs1;
  assign raddr1_2 = instr1.r.rs2;

  assign alu0_a = fdata0_1;
  assign alu0_b = operand_b(instr0, fdata0_2);
  assign alu0_funct3 = instr0.r.funct3;
  assign alu0_alt = alu_alt(instr0);
  assign alu1_a = fdata1_1;
  assign alu1_b = operand_b(instr1, fdata1_2);
  assign alu1_funct3 = instr1.r.funct3;
  assign alu1_alt = alu_alt(instr1);

  always_comb begin
    is_div0 = instr0.r.opcode == opcode_op && instr0.r.funct7 == funct7_muldiv &&
              instr0.r.funct3[2];
    wb0 = (alu_legal(instr0) || is_div0) && instr0.r.rd != '0;
    // Lane 1 has no divider path, a divide there falls out as a nop
    wb1 = alu_legal(instr1) && instr1.r.rd != '0;
    accept = issue_valid & issue_ready;
    div_done = pending & div.ack;
  end

  // ------------------------------
  // Stall and result register
  // ------------------------------
  assign issue_ready = ~pending;
  assign div.req = pending;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      pending <= 0;
      hold_valid0 <= 0;
      hold_valid1 <= 0;
      res_valid0 <= 0;
      res_valid1 <= 0;
    end else if (pending) begin
      if (div_done) begin
        pending <= 0;
        res_valid0 <= hold_valid0;
        res_valid1 <= hold_valid1;
      end
    end else begin
      res_valid0 <= accept & wb0 & ~is_div0;
      res_valid1 <= accept & wb1 & ~is_div0;
      if (accept && is_div0) begin
        pending <= 1;
        hold_valid0 <= wb0;
        hold_valid1 <= wb1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      res_rd0 <= instr0.r.rd;
      res_data0 <= alu0_result;
      res_rd1 <= instr1.r.rd;
      res_data1 <= alu1_result;
      div.op <= instr0.r.funct3[1:0];
      div.dividend <= fdata0_1;
      div.divisor <= fdata0_2;
    end else if (div_done) begin
      res_data0 <= div.result;
    end
  end

endmodule

//--- source/forwarding_unit.sv
module forwarding_unit
  import core_pkg::*;
(
  input  logic [reg_addr_width-1:0] raddr0_1,
  input  logic [reg_addr_width-1:0] raddr0_2,
  input  logic [reg_addr_width-1:0] raddr1_1,
  input  logic [reg_addr_width-1:0] raddr1_2,
  input  logic [xlen-1:0] rdata0_1,
  input  logic [xlen-1:0] rdata0_2,
  input  logic [xlen-1:0] rdata1_1,
  input  logic [xlen-1:0] rdata1_2,
  input  logic res_valid0,
  input  logic [reg_addr_width-1:0] res_rd0,
  input  logic [xlen-1:0] res_data0,
  input  logic res_valid1,
  input  logic [reg_addr_width-1:0] res_rd1,
  input  logic [xlen-1:0] res_data1,
  output logic [xlen-1:0] fdata0_1,
  output logic [xlen-1:0] fdata0_2,
  output logic [xlen-1:0] fdata1_1,
  output logic [xlen-1:0] fdata1_2
);

  logic [reg_addr_width-1:0] raddr [4];
  logic [xlen-1:0] rdata [4];
  logic [xlen-1:0] fdata [4];

  assign raddr = '{raddr0_1, raddr0_2, raddr1_1, raddr1_2};
  assign rdata = '{rdata0_1, rdata0_2, rdata1_1, rdata1_2};

  // Lane 1 is younger, so its result wins over lane 0
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (raddr[i] == '0) begin
        fdata[i] = '0;
      end else if (res_valid1 && res_rd1 == raddr[i]) begin
        fdata[i] = res_data1;
      end else if (res_valid0 && res_rd0 == raddr[i]) begin
        fdata[i] = res_data0;
      end else begin
        fdata[i] = rdata[i];
      end
    end
  end

  assign fdata0_1 = fdata[0];
  assign fdata0_2 = fdata[1];
  assign fdata1_1 = fdata[2];
  assign fdata1_2 = fdata[3];

endmodule

//--- source/register_file.sv
module register_file
  import core_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic [reg_addr_width-1:0] raddr0_1,
  input  logic [reg_addr_width-1:0] raddr0_2,
  input  logic [reg_addr_width-1:0] raddr1_1,
  input  logic [reg_addr_width-1:0] raddr1_2,
  output logic [xlen-1:0] rdata0_1,
  output logic [xlen-1:0] rdata0_2,
  output logic [xlen-1:0] rdata1_1,
  output logic [xlen-1:0] rdata1_2,
  input  logic wen0,
  input  logic [reg_addr_width-1:0] waddr0,
  input  logic [xlen-1:0] wdata0,
  input  logic wen1,
  input  logic [reg_addr_width-1:0] waddr1,
  input  logic [xlen-1:0] wdata1
);

  logic [xlen-1:0] regs [2**reg_addr_width];

  assign rdata0_1 = regs[raddr0_1];
  assign rdata0_2 = regs[raddr0_2];
  assign rdata1_1 = regs[raddr1_1];
  assign rdata1_2 = regs[raddr1_2];

  // x0 is never written, so it reads zero after reset
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wen0 && waddr0 != '0) begin
        regs[waddr0] <= wdata0;
      end
      if (wen1 && waddr1 != '0) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

endmodule

//--- testbench/execute_core_asserts.sv
module execute_core_asserts (
  input logic clock,
  input logic reset,
  input logic req,
  input logic ack,
  input logic issue_ready,
  input logic wb_valid0,
  input logic wb_valid1
);

  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // Divider handshake
  // ------------------------------
  req_holds_until_ack: assert property (
    @(posedge clock) disable iff (!reset) req && !ack |=> req
  ) else $error("div req fell before ack");

  ack_needs_req: assert property (
    @(posedge clock) disable iff (!reset) $rose(ack) |-> req
  ) else $error("div ack rose while req was low");

  req_low_after_reset: assert property (
    @(posedge clock) !reset |=> !req
  ) else $error("div req high in the cycle after reset");

  // ------------------------------
  // Stall
  // ------------------------------
  // Nothing is written back while the stage stalls on a divide
  no_writeback_in_stall: assert property (
    @(posedge clock) disable iff (!reset) !issue_ready |-> !wb_valid0 && !wb_valid1
  ) else $error("writeback seen while the stage stalled");

endmodule

//--- testbench/execute_core_tb.sv
module execute_core_tb
  import core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic clock;
  logic reset;
  logic issue_valid;
  instr_word_t instr0;
  instr_word_t instr1;
  logic issue_ready;
  logic wb_valid0, wb_valid1;
  logic [reg_addr_width-1:0] wb_rd0, wb_rd1;
  logic [xlen-1:0] wb_data0, wb_data1;

  // Five words per pair: instr0, instr1, gap, expected data0, expected data1
  logic [31:0] stim [160];
  logic [xlen-1:0] model_regs [32];
  int n_pairs;
  int limit;
  int cycles;
  logic exp_valid0, exp_valid1, exp_div;
  logic [reg_addr_width-1:0] exp_rd0, exp_rd1;
  logic [xlen-1:0] exp_data0, exp_data1;
  bit outstanding;
  bit first_check;

  execute_core UUT (
    .clock, .reset, .issue_valid, .instr0, .instr1, .issue_ready,
    .wb_valid0, .wb_rd0, .wb_data0, .wb_valid1, .wb_rd1, .wb_data1
  );

  bind execute_core execute_core_asserts handshake_checks (
    .clock(clock), .reset(reset), .req(div_bus.req), .ack(div_bus.ack),
    .issue_ready(issue_ready), .wb_valid0(wb_valid0), .wb_valid1(wb_valid1)
  );

  initial begin
    clock = 0;
    forever #20 clock = ~clock;
  end

  // ------------------------------
  // Reporting and compares
  // ------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_rd(input string name, input logic [reg_addr_width-1:0] got,
                          input logic [reg_addr_width-1:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_data(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("error: %s got %h expected %h", name, got, expected));
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [xlen-1:0] alu_model(logic [2:0] funct3, logic alt,
                                                logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (funct3)
      funct3_add: return alt ? a - b : a + b;
      funct3_sll: return a << b[4:0];
      funct3_slt: return {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
      funct3_sltu: return {{(xlen - 1){1'b0}}, a < b};
      funct3_xor: return a ^ b;
      funct3_srl: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      funct3_or: return a | b;
      default: return a & b;
    endcase
  endfunction

  // RV32M rules, including division by zero and the signed overflow case
  function automatic logic [xlen-1:0] div_model(logic [2:0] funct3, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
    logic overflow;
    logic signed [xlen-1:0] quo, rem;
    overflow = (a == {1'b1, {(xlen - 1){1'b0}}}) && (b == '1);
    quo = '0;
    rem = '0;
    if (!overflow && b != 0) begin
      quo = $signed(a) / $signed(b);
      rem = $signed(a) % $signed(b);
    end
    case (funct3)
      funct3_div: return (b == 0) ? '1 : (overflow ? a : quo);
      funct3_divu: return (b == 0) ? '1 : a / b;
      funct3_rem: return (b == 0) ? a : (overflow ? '0 : rem);
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  task automatic model_lane(input instr_word_t w, input logic lane0, output logic wr,
                            output logic dv, output logic [xlen-1:0] val);
    logic [xlen-1:0] a, b;
    logic legal, alt;
    a = model_regs[w.r.rs1];
    b = model_regs[w.r.rs2];
    legal = 0;
    dv = 0;
    val = '0;
    if (w.r.opcode == opcode_op) begin
      alt = w.r.funct7 == funct7_alt;
      if (w.r.funct7 == funct7_base ||
          (alt && (w.r.funct3 == funct3_add || w.r.funct3 == funct3_srl))) begin
        legal = 1;
        val = alu_model(w.r.funct3, alt, a, b);
      end else if (lane0 && w.r.funct7 == funct7_muldiv && w.r.funct3[2]) begin
        legal = 1;
        dv = 1;
        val = div_model(w.r.funct3, a, b);
      end
    end else if (w.i.opcode == opcode_op_imm) begin
      b = {{(xlen - 12){w.i.imm[11]}}, w.i.imm};
      alt = w.i.funct3 == funct3_srl && w.r.funct7 == funct7_alt;
      if (w.i.funct3 == funct3_sll || w.i.funct3 == funct3_srl) begin
        legal = w.r.funct7 == funct7_base || alt;
      end else begin
        legal = 1;
      end
      val = alu_model(w.i.funct3, alt, a, b);
    end
    wr = legal && w.r.rd != '0;
  endtask

  task automatic apply_pair(input int i);
    instr_word_t w0, w1;
    logic lane1_div;
    w0 = stim[i * 5];
    w1 = stim[i * 5 + 1];
    // Both lanes read the registers as they were before the pair
    model_lane(w0, 1'b1, exp_valid0, exp_div, exp_data0);
    model_lane(w1, 1'b0, exp_valid1, lane1_div, exp_data1);
    exp_rd0 = w0.r.rd;
    exp_rd1 = w1.r.rd;
    if (exp_valid0) begin
      model_regs[exp_rd0] = exp_data0;
      check_data("model wb_data0", exp_data0, stim[i * 5 + 3]);
    end
    if (exp_valid1) begin
      model_regs[exp_rd1] = exp_data1;
      check_data("model wb_data1", exp_data1, stim[i * 5 + 4]);
    end
    outstanding = 1;
    first_check = 1;
  endtask

  // Sampled on the falling edge, half a cycle away from any input change
  task automatic check_outputs();
    if (outstanding && first_check) begin
      check_flag("issue_ready", issue_ready, !exp_div);
    end
    first_check = 0;
    if (outstanding && issue_ready) begin
      check_flag("wb_valid0", wb_valid0, exp_valid0);
      check_flag("wb_valid1", wb_valid1, exp_valid1);
      if (exp_valid0) begin
        check_rd("wb_rd0", wb_rd0, exp_rd0);
        check_data("wb_data0", wb_data0, exp_data0);
      end
      if (exp_valid1) begin
        check_rd("wb_rd1", wb_rd1, exp_rd1);
        check_data("wb_data1", wb_data1, exp_data1);
      end
      outstanding = 0;
    end else begin
      check_flag("wb_valid0", wb_valid0, 1'b0);
      check_flag("wb_valid1", wb_valid1, 1'b0);
      if (!outstanding) begin
        check_flag("issue_ready", issue_ready, 1'b1);
      end
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    bit accept_next;
    int idx;
    int gap_left;
    reset = 0;
    issue_valid = 0;
    instr0 = nop_word;
    instr1 = nop_word;
    outstanding = 0;
    first_check = 0;
    limit = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    $readmemh("testbench/execute_core_testdata.txt", stim);
    n_pairs = 0;
    while (n_pairs < $size(stim) / 5 && !$isunknown(stim[n_pairs * 5])) begin
      n_pairs++;
    end
    if (n_pairs == 0) begin
      fail_run("no issue pairs were read from the test data file");
    end
    limit = n_pairs * 40 + 100;
    repeat (16) @(posedge clock);
    reset <= 1;
    accept_next = 0;
    idx = 0;
    gap_left = 0;
    while (idx < n_pairs || outstanding) begin
      @(posedge clock);
      if (accept_next) begin
        apply_pair(idx);
        gap_left = stim[idx * 5 + 2];
        idx++;
      end
      if (idx < n_pairs && gap_left == 0) begin
        instr0 <= stim[idx * 5];
        instr1 <= stim[idx * 5 + 1];
        issue_valid <= 1;
      end else begin
        instr0 <= nop_word;
        instr1 <= nop_word;
        issue_valid <= 0;
        if (gap_left > 0) begin
          gap_left--;
        end
      end
      @(negedge clock);
      check_outputs();
      accept_next = issue_valid && issue_ready;
    end
    $display("Verification passed");
    $finish;
  end

  initial begin
    cycles = 0;
    while (limit == 0 || cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    fail_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
  end

endmodule

//--- testbench/execute_core_testdata.txt
// instr0   instr1   gap  data0    data1    (all hex)
// gap is the idle cycles after the pair, data columns are the expected writebacks
FF900093 06400113 0 FFFFFFF9 00000064
401101B3 0020C233 0 0000006B FFFFFF9D
001112B3 4020D333 0 C8000000 FFFFFFFF
0020A3B3 0020B433 1 00000001 00000000
0020D4B3 0020E533 0 0FFFFFFF FFFFFFFD
0020F5B3 004185B3 0 00000060 00000008
FFF0A613 FFF0B693 0 00000001 00000001
05514713 1230E793 0 00000031 FFFFFFFB
0F00F813 00311893 0 000000F0 00000320
0040D913 4040D993 2 0FFFFFFF FFFFFFFF
02114A33 001A0A93 0 FFFFFFF2 00000001
02116B33 015A0BB3 0 00000002 FFFFFFF3
0220DC33 00100E93 0 028F5C28 00000001
0200FD33 02114DB3 1 FFFFFFF9 00000000
0200CE33 FFF00F13 0 FFFFFFFF FFFFFFFF
01FE9E93 00510013 0 80000000 00000000
03EEC2B3 00000FB3 0 80000000 00000000
03EEE333 41EE83B3 0 00000000 80000001
